/* hdl/adc_pkg.sv */
// bus offsets decode the full SYS_AW address with no aliasing; tap counters wrap modulo 32
package adc_pkg;

  //////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////

  localparam int SYS_AW = 20;  // byte address
  localparam int SYS_DW = 32;  // data word

  // idelay style tap counter
  localparam int TAP_W = 5;

  //////////////////////////////////////////////////
  // register map (byte offsets)
  //////////////////////////////////////////////////

  localparam logic [SYS_AW-1:0] REG_LED     = 20'h00;  // led value, r/w
  localparam logic [SYS_AW-1:0] REG_TAP_CMD = 20'h04;  // tap command, write only
  localparam logic [SYS_AW-1:0] REG_TAP_CNT = 20'h08;  // both tap counts, read only
  localparam logic [SYS_AW-1:0] REG_SMP_CH0 = 20'h0C;  // latest ch0 sample
  localparam logic [SYS_AW-1:0] REG_SMP_CH1 = 20'h10;  // latest ch1 sample

  //////////////////////////////////////////////////
  // write word views
  //////////////////////////////////////////////////

  // led register view
  typedef struct packed {
    logic [SYS_DW-9:0] rsvd;  // 31..8 unused
    logic [7:0]        led;   // led value
  } hk_led_t;

  // tap command view
  typedef struct packed {
    logic [SYS_DW-7:0] rsvd;    // 31..6 unused
    logic [1:0]        ch_msk;  // bit 5 ch1 / bit 4 ch0
    logic              rsvd3;   // bit 3 unused
    logic              inc;     // 1 up, 0 down
    logic              ce;      // step enable
    logic              ld;      // clear counter
  } hk_tap_cmd_t;

  // one bus word, decoded by offset
  typedef union packed {
    hk_led_t     led;
    hk_tap_cmd_t tap;
  } hk_wdata_u;

endpackage

/* hdl/adc_lane_capture.sv */
// frm_i must mark the even word; a frame marker in the odd cycle is ignored, no lane skew fix
module adc_lane_capture #(
  parameter int LANE_W = 7  // pins per lane
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // lane
  input  logic [LANE_W-1:0]          lane_i,     // even bits, then odd bits
  input  logic                       frm_i,      // high with the even word
  // tap commands from the register bank
  input  logic                       tap_ld_i,   // clear
  input  logic                       tap_ce_i,   // step
  input  logic                       tap_inc_i,  // direction of step
  // sample out
  output logic signed [2*LANE_W-1:0] smp_o,
  output logic                       smp_vld_o,
  output logic [adc_pkg::TAP_W-1:0]  tap_cnt_o
);

  localparam int SMP_W = 2*LANE_W;  // full sample width

  logic [LANE_W-1:0] even_q;      // even half
  logic              odd_pend_q;  // next lane word is the odd half
  logic              frm_take;    // accepted frame marker
  logic [SMP_W-1:0]  raw;         // merged unsigned code
  logic [SMP_W-1:0]  smp_2c;      // two's complement view

  //////////////////////////////////////////////////
  // deinterleave
  //////////////////////////////////////////////////

  // marker is only taken when no odd word is due
  assign frm_take = frm_i & ~odd_pend_q;

  // even half, held for the odd cycle
  always_ff @(posedge clk_i)
  begin
    if (frm_take)
    begin
      even_q <= lane_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      odd_pend_q <= 1'b0;
    end
    else
    begin
      odd_pend_q <= frm_take;  // one cycle after the even word
    end
  end

  // pin k carries bit 2k first, bit 2k+1 second
  always_comb
  begin
    for (int k = 0; k < LANE_W; k++)
    begin
      raw[2*k]   = even_q[k];
      raw[2*k+1] = lane_i[k];  // odd word straight from the lane
    end
  end

  //////////////////////////////////////////////////
  // code conversion
  //////////////////////////////////////////////////

  // unsigned negative slope to two's complement
  // msb kept, lower bits inverted
  assign smp_2c = {raw[SMP_W-1], ~raw[SMP_W-2:0]};

  // sample register
  always_ff @(posedge clk_i)
  begin
    if (odd_pend_q)
    begin
      smp_o <= smp_2c;
    end
  end

  // valid pulse aligned with the new sample
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      smp_vld_o <= 1'b0;
    end
    else
    begin
      smp_vld_o <= odd_pend_q;
    end
  end

  //////////////////////////////////////////////////
  // tap counter
  //////////////////////////////////////////////////

  // behaves like a variable input delay
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      tap_cnt_o <= '0;
    end
    else if (tap_ld_i)
    begin
      tap_cnt_o <= '0;  // load wins over step
    end
    else if (tap_ce_i)
    begin
      if (tap_inc_i)
      begin
        tap_cnt_o <= tap_cnt_o + 1'b1;  // 31 wraps to 0
      end
      else
      begin
        tap_cnt_o <= tap_cnt_o - 1'b1;  // 0 wraps to 31
      end
    end
  end

endmodule

/* hdl/adc_hk_regs.sv */
// single request outstanding, ack one cycle later; no byte enables, writes are always 32 bit
module adc_hk_regs #(
  parameter int LANE_W = 7  // pins per lane
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // system bus
  input  logic [adc_pkg::SYS_AW-1:0] sys_addr_i,
  input  logic [adc_pkg::SYS_DW-1:0] sys_wdata_i,
  input  logic                       sys_wen_i,
  input  logic                       sys_ren_i,
  output logic [adc_pkg::SYS_DW-1:0] sys_rdata_o,
  output logic                       sys_ack_o,
  output logic                       sys_err_o,
  // channel side
  input  logic signed [2*LANE_W-1:0] smp0_i,
  input  logic signed [2*LANE_W-1:0] smp1_i,
  input  logic                       smp0_vld_i,
  input  logic                       smp1_vld_i,
  input  logic [adc_pkg::TAP_W-1:0]  tap_cnt0_i,
  input  logic [adc_pkg::TAP_W-1:0]  tap_cnt1_i,
  // led
  output logic [7:0]                 led_o,
  // tap commands, bit n goes to channel n
  output logic [1:0]                 tap_ld_o,
  output logic [1:0]                 tap_ce_o,
  output logic [1:0]                 tap_inc_o
);

  localparam int SMP_W    = 2*LANE_W;           // sample width
  localparam int DW       = adc_pkg::SYS_DW;    // short alias
  localparam int TAP_LSB0 = 0;                  // ch0 count position
  localparam int TAP_LSB1 = 8;                  // ch1 count position

  adc_pkg::hk_wdata_u wd;  // write word, two views

  logic          hit_led;
  logic          hit_cmd;
  logic          hit_cnt;
  logic          hit_s0;
  logic          hit_s1;
  logic          mapped;   // any known offset
  logic          req;      // read or write this cycle
  logic [DW-1:0] rd_mux;   // read data before the register
  logic [DW-1:0] tap_rd;   // packed tap counts

  logic signed [SMP_W-1:0] smp0_q;  // latest ch0 sample
  logic signed [SMP_W-1:0] smp1_q;  // latest ch1 sample

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  assign wd = sys_wdata_i;

  assign hit_led = (sys_addr_i == adc_pkg::REG_LED);
  assign hit_cmd = (sys_addr_i == adc_pkg::REG_TAP_CMD);
  assign hit_cnt = (sys_addr_i == adc_pkg::REG_TAP_CNT);
  assign hit_s0  = (sys_addr_i == adc_pkg::REG_SMP_CH0);
  assign hit_s1  = (sys_addr_i == adc_pkg::REG_SMP_CH1);

  assign mapped = hit_led | hit_cmd | hit_cnt | hit_s0 | hit_s1;
  assign req    = sys_wen_i | sys_ren_i;

  //////////////////////////////////////////////////
  // held samples
  //////////////////////////////////////////////////

  // refreshed on each valid pulse
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      smp0_q <= '0;
      smp1_q <= '0;
    end
    else
    begin
      if (smp0_vld_i)
      begin
        smp0_q <= smp0_i;
      end
      if (smp1_vld_i)
      begin
        smp1_q <= smp1_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////

  // ch0 in 4..0, ch1 in 12..8
  always_comb
  begin
    tap_rd               = '0;
    tap_rd[TAP_LSB0 +: adc_pkg::TAP_W] = tap_cnt0_i;
    tap_rd[TAP_LSB1 +: adc_pkg::TAP_W] = tap_cnt1_i;
  end

  always_comb
  begin
    rd_mux = '0;  // unmapped and tap command read zero
    if (hit_led)
    begin
      rd_mux[7:0] = led_o;
    end
    else if (hit_cnt)
    begin
      rd_mux = tap_rd;
    end
    else if (hit_s0)
    begin
      rd_mux = {{(DW-SMP_W){smp0_q[SMP_W-1]}}, smp0_q};  // sign extend
    end
    else if (hit_s1)
    begin
      rd_mux = {{(DW-SMP_W){smp1_q[SMP_W-1]}}, smp1_q};
    end
  end

  //////////////////////////////////////////////////
  // bus response
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end
    else
    begin
      sys_ack_o   <= req;             // always one cycle
      sys_err_o   <= req & ~mapped;   // unknown offset
      sys_rdata_o <= sys_ren_i ? rd_mux : '0;
    end
  end

  //////////////////////////////////////////////////
  // led register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      led_o <= '0;
    end
    else if (sys_wen_i && hit_led)
    begin
      led_o <= wd.led.led;
    end
  end

  //////////////////////////////////////////////////
  // tap command fan out
  //////////////////////////////////////////////////

  // pulses line up with the write ack
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      tap_ld_o  <= '0;
      tap_ce_o  <= '0;
      tap_inc_o <= '0;
    end
    else if (sys_wen_i && hit_cmd)
    begin
      tap_ld_o  <= {2{wd.tap.ld}}  & wd.tap.ch_msk;  // masked per channel
      tap_ce_o  <= {2{wd.tap.ce}}  & wd.tap.ch_msk;
      tap_inc_o <= {2{wd.tap.inc}} & wd.tap.ch_msk;
    end
    else
    begin
      tap_ld_o  <= '0;  // single cycle only
      tap_ce_o  <= '0;
      tap_inc_o <= '0;
    end
  end

endmodule

/* hdl/adc_rx_top.sv */
// behavioural lane receive only; no pad buffers, delay lines or ddr cells, one clock domain
module adc_rx_top #(
  parameter int LANE_W = 7  // pins per lane, sample is twice this
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // adc lanes
  input  logic [LANE_W-1:0]          adc_dat0_i,  // ch0 lane
  input  logic [LANE_W-1:0]          adc_dat1_i,  // ch1 lane
  input  logic                       adc_frm_i,   // shared frame marker
  // system bus
  input  logic [adc_pkg::SYS_AW-1:0] sys_addr_i,
  input  logic [adc_pkg::SYS_DW-1:0] sys_wdata_i,
  input  logic                       sys_wen_i,
  input  logic                       sys_ren_i,
  output logic [adc_pkg::SYS_DW-1:0] sys_rdata_o,
  output logic                       sys_ack_o,
  output logic                       sys_err_o,
  // board leds
  output logic [7:0]                 led_o
);

  localparam int SMP_W = 2*LANE_W;

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  logic signed [SMP_W-1:0]          smp0;
  logic signed [SMP_W-1:0]          smp1;
  logic                             smp0_vld;
  logic                             smp1_vld;
  logic [adc_pkg::TAP_W-1:0]        tap_cnt0;
  logic [adc_pkg::TAP_W-1:0]        tap_cnt1;
  logic [1:0]                       tap_ld;   // bit n to channel n
  logic [1:0]                       tap_ce;
  logic [1:0]                       tap_inc;

  //////////////////////////////////////////////////
  // channel captures
  //////////////////////////////////////////////////

  adc_lane_capture #(.LANE_W (LANE_W)) ch0 (
    .clk_i     (clk_i     ),
    .rst_n_i   (rst_n_i   ),
    .lane_i    (adc_dat0_i),
    .frm_i     (adc_frm_i ),
    .tap_ld_i  (tap_ld[0] ),
    .tap_ce_i  (tap_ce[0] ),
    .tap_inc_i (tap_inc[0]),
    .smp_o     (smp0      ),
    .smp_vld_o (smp0_vld  ),
    .tap_cnt_o (tap_cnt0  )
  );

  adc_lane_capture #(.LANE_W (LANE_W)) ch1 (
    .clk_i     (clk_i     ),
    .rst_n_i   (rst_n_i   ),
    .lane_i    (adc_dat1_i),
    .frm_i     (adc_frm_i ),  // same marker as ch0
    .tap_ld_i  (tap_ld[1] ),
    .tap_ce_i  (tap_ce[1] ),
    .tap_inc_i (tap_inc[1]),
    .smp_o     (smp1      ),
    .smp_vld_o (smp1_vld  ),
    .tap_cnt_o (tap_cnt1  )
  );

  //////////////////////////////////////////////////
  // housekeeping
  //////////////////////////////////////////////////

  adc_hk_regs #(.LANE_W (LANE_W)) hk (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .sys_addr_i  (sys_addr_i ),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i  ),
    .sys_ren_i   (sys_ren_i  ),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o  ),
    .sys_err_o   (sys_err_o  ),
    .smp0_i      (smp0       ),
    .smp1_i      (smp1       ),
    .smp0_vld_i  (smp0_vld   ),
    .smp1_vld_i  (smp1_vld   ),
    .tap_cnt0_i  (tap_cnt0   ),
    .tap_cnt1_i  (tap_cnt1   ),
    .led_o       (led_o      ),
    .tap_ld_o    (tap_ld     ),
    .tap_ce_o    (tap_ce     ),
    .tap_inc_o   (tap_inc    )
  );

endmodule

/* tests/adc_rx_checker.sv */
// bus and strobe protocol assertions, bound into every adc_rx_top; checks are off while in reset
module adc_rx_checker (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic sys_wen_i,
  input  logic sys_ren_i,
  input  logic sys_ack_i,
  input  logic sys_err_i,
  input  logic smp0_vld_i,
  input  logic smp1_vld_i
);

  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////////////////////////
  // bus response
  //////////////////////////////////////////////////

  ack_after_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (sys_wen_i || sys_ren_i) |=> sys_ack_i)
    else $error("bus ack missing one cycle after request");

  ack_needs_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sys_ack_i |-> $past(sys_wen_i || sys_ren_i))
    else $error("bus ack without a request");

  err_with_ack : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sys_err_i |-> sys_ack_i)
    else $error("bus err raised without ack");

  // sample strobes are single pulses
  vld0_single : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    smp0_vld_i |=> !smp0_vld_i)
    else $error("ch0 sample valid high two cycles in a row");

  vld1_single : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    smp1_vld_i |=> !smp1_vld_i)
    else $error("ch1 sample valid high two cycles in a row");

endmodule

bind adc_rx_top adc_rx_checker chk0 (
  .clk_i      (clk_i    ),
  .rst_n_i    (rst_n_i  ),
  .sys_wen_i  (sys_wen_i),
  .sys_ren_i  (sys_ren_i),
  .sys_ack_i  (sys_ack_o),
  .sys_err_i  (sys_err_o),
  .smp0_vld_i (smp0_vld ),
  .smp1_vld_i (smp1_vld )
);

/* tests/adc_rx_tb.sv */
// inputs change on the falling edge only; sample reads assume the fixed 2 cycle capture latency
module adc_rx_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LANE_W  = 7;
  localparam int N_ROWS  = 10;  // 4 fixed rows, rest random
  localparam int TIMEOUT = 20;  // cycles per ack wait

  logic              clk;
  logic              rst_n;
  logic [LANE_W-1:0] dat0;
  logic [LANE_W-1:0] dat1;
  logic              frm;
  logic [19:0]       addr;
  logic [31:0]       wdata;
  logic              wen;
  logic              ren;
  logic [31:0]       rdata;
  logic              ack;
  logic              err;
  logic [7:0]        led;

  int mism_cnt = 0;
  int tout_cnt = 0;

  logic [13:0] raw_tab [N_ROWS][2];  // raw codes per channel
  logic [13:0] exp_tab [N_ROWS][2];  // converted codes
  logic [31:0] rnd = 32'h628b;

  adc_rx_top #(.LANE_W (LANE_W)) dut0 (
    .clk_i (clk), .rst_n_i (rst_n),
    .adc_dat0_i (dat0), .adc_dat1_i (dat1), .adc_frm_i (frm),
    .sys_addr_i (addr), .sys_wdata_i (wdata), .sys_wen_i (wen), .sys_ren_i (ren),
    .sys_rdata_o (rdata), .sys_ack_o (ack), .sys_err_o (err), .led_o (led)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // negative slope, raw zero is the top positive code
  function automatic logic [13:0] convert(input logic [13:0] r);
    return 14'h1FFF - r;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      mism_cnt++;
      $display("MISMATCH %s got %h exp %h", name, got, exp);
    end
  endtask

  // one request, then poll ack on falling edges
  task automatic bus_op(input logic wr, input logic [19:0] a, input logic [31:0] d);
    int n;
    @(negedge clk);
    addr  = a;
    wdata = d;
    wen   = wr;
    ren   = ~wr;
    @(negedge clk);
    wen = 1'b0;
    ren = 1'b0;
    n   = 0;
    while (!ack && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (!ack)
    begin
      tout_cnt++;
      $display("timeout: no bus ack for access at offset %h", a);
    end
  endtask

  task automatic read_expect(input logic [19:0] a, input logic [31:0] exp, input logic exp_err);
    bus_op(1'b0, a, 32'h0);
    check_val("sys_rdata_o", rdata, exp);
    check_val("sys_err_o", {31'b0, err}, {31'b0, exp_err});
  endtask

  // even bits with the frame marker, odd bits next cycle
  task automatic send_sample(input logic [13:0] r0, input logic [13:0] r1);
    @(negedge clk);
    frm = 1'b1;
    for (int k = 0; k < LANE_W; k++)
    begin
      dat0[k] = r0[2*k];
      dat1[k] = r1[2*k];
    end
    @(negedge clk);
    frm = 1'b0;
    for (int k = 0; k < LANE_W; k++)
    begin
      dat0[k] = r0[2*k+1];
      dat1[k] = r1[2*k+1];
    end
    @(negedge clk);
    dat0 = '0;
    dat1 = '0;  // next read lands after the bank holds it
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial
  begin
    logic [31:0] cmd_tab [8];
    logic [4:0]  mdl [2];  // model tap counters
    rst_n = 1'b0;
    dat0  = '0;
    dat1  = '0;
    frm   = 1'b0;
    addr  = '0;
    wdata = '0;
    wen   = 1'b0;
    ren   = 1'b0;
    cmd_tab = '{32'h36, 32'h36, 32'h12, 32'h26, 32'h11, 32'h12, 32'h27, 32'h26};
    mdl     = '{5'd0, 5'd0};
    raw_tab[0] = '{14'h0000, 14'h3FFF};  // end points of the code range
    exp_tab[0] = '{14'h1FFF, 14'h2000};
    raw_tab[1] = '{14'h2000, 14'h1FFF};  // around mid scale
    exp_tab[1] = '{14'h3FFF, 14'h0000};
    raw_tab[2] = '{14'h2AAA, 14'h1555};
    exp_tab[2] = '{14'h3555, 14'h0AAA};
    raw_tab[3] = '{14'h0001, 14'h3FFE};
    exp_tab[3] = '{14'h1FFE, 14'h2001};
    for (int i = 4; i < N_ROWS; i++)
    begin
      rnd = next_rand(rnd);
      raw_tab[i] = '{rnd[13:0], rnd[29:16]};
      exp_tab[i] = '{convert(rnd[13:0]), convert(rnd[29:16])};
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // everything reads zero out of reset
    read_expect(20'h00, 32'h0, 1'b0);
    read_expect(20'h08, 32'h0, 1'b0);
    read_expect(20'h0C, 32'h0, 1'b0);
    read_expect(20'h10, 32'h0, 1'b0);

    for (int i = 0; i < N_ROWS; i++)
    begin
      send_sample(raw_tab[i][0], raw_tab[i][1]);
      read_expect(20'h0C, {{18{exp_tab[i][0][13]}}, exp_tab[i][0]}, 1'b0);  // sign extended
      read_expect(20'h10, {{18{exp_tab[i][1][13]}}, exp_tab[i][1]}, 1'b0);
    end

    bus_op(1'b1, 20'h00, 32'hFFFF_FFA5);  // upper bits ignored
    read_expect(20'h00, 32'hA5, 1'b0);
    check_val("led_o", {24'b0, led}, 32'hA5);

    // bit0 load, bit1 step, bit2 up, bits 5..4 mask
    foreach (cmd_tab[c])
    begin
      bus_op(1'b1, 20'h04, cmd_tab[c]);
      for (int ch = 0; ch < 2; ch++)
      begin
        if (cmd_tab[c][4+ch] && cmd_tab[c][0])
          mdl[ch] = 5'd0;
        else if (cmd_tab[c][4+ch] && cmd_tab[c][1])
          mdl[ch] = cmd_tab[c][2] ? mdl[ch] + 5'd1 : mdl[ch] - 5'd1;
      end
      read_expect(20'h08, {19'b0, mdl[1], 3'b0, mdl[0]}, 1'b0);
    end

    read_expect(20'h14, 32'h0, 1'b1);   // first hole past the map
    read_expect(20'h800, 32'h0, 1'b1);

    $display("errors: mismatches %0d, timeouts %0d", mism_cnt, tout_cnt);
    if (mism_cnt == 0 && tout_cnt == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* adc_rx_top.f */
hdl/adc_pkg.sv
hdl/adc_lane_capture.sv
hdl/adc_hk_regs.sv
hdl/adc_rx_top.sv
tests/adc_rx_checker.sv
tests/adc_rx_tb.sv
